// ==== all.f ====
+incdir+include
verilog/mipsIsaPkg.sv
verilog/pipePkg.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWriteback.sv
verilog/mipsPipe.sv
test/mipsPipeTb.sv

// ==== Bender.yml ====
package:
  name: mipsPipe

sources:
  - files:
      - verilog/mipsIsaPkg.sv
      - verilog/pipePkg.sv
      - verilog/controlDecoder.sv
      - verilog/regFile.sv
      - verilog/fetchStage.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/memWriteback.sv
      - verilog/mipsPipe.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - test/mipsPipeTb.sv

// ==== include/tbPrograms.svh ====
// program table for the pipeline testbench
// per test: name, program words, two data words at byte address 0 and 4,
// and the stores it must make in order as address and data pairs
`ifndef tbProgramsSvh
`define tbProgramsSvh

localparam int numTests = 5;
localparam int maxInst = 16;
localparam int maxStores = 6;
localparam int imemWords = 32;  // 5 index bits
localparam int dmemWords = 64;  // 6 index bits

string testName [numTests] = '{"aluChain", "loadUse", "branchLoop", "jumpSkip", "zeroReg"};
int instCount [numTests] = '{16, 12, 13, 7, 7};
int storeCount [numTests] = '{6, 4, 6, 1, 2};

mipsIsaPkg::wordT progTable [numTests][maxInst] = '{
  // addi r1,5; addi r2,12; add r3=17; sub r4=12; and r5=0; or r6=29
  // slt r7,r6,r1=0; addi r8,-3; slt r9,r8,r1=1 signed; sw r3..r7,r9; j self
  '{32'h20010005, 32'h2002000c, 32'h00221820, 32'h00612022,
    32'h00642824, 32'h00833025, 32'h00c1382a, 32'h2008fffd,
    32'h0101482a, 32'hac030000, 32'hac040004, 32'hac050008,
    32'hac06000c, 32'hac070010, 32'hac090014, 32'h0800000f},
  // lw r1,0; addi r2,r1,7; sw r2,32; lw r3,4; add r4,r3,r3; sw r4,36
  // lw r5,4; sw r5,40; lw r6,32; addi r7,r6,1; sw r7,44; j self
  '{32'h8c010000, 32'h20220007, 32'hac020020, 32'h8c030004,
    32'h00632020, 32'hac040024, 32'h8c050004, 32'hac050028,
    32'h8c060020, 32'h20c70001, 32'hac07002c, 32'h0800000b,
    32'h0, 32'h0, 32'h0, 32'h0},
  // r1=3 r2=0; loop: sw r1,64(r2); r2+=4; r1-=1; bne r1,r0,loop
  // sw r1,128 in the slot; beq r1,r2 not taken; sw r2,132
  // beq r0,r0 over sw r1,136; sw r2,140; j self
  '{32'h20010003, 32'h20020000, 32'hac410040, 32'h20420004,
    32'h2021ffff, 32'h1420fffc, 32'hac010080, 32'h10220001,
    32'hac020084, 32'h10000001, 32'hac010088, 32'hac02008c,
    32'h0800000c, 32'h0, 32'h0, 32'h0},
  // addi r1,9; j 16 over sw r1,0 and sw r1,8; addi r1,r1,6; sw r1,4; j self
  '{32'h20010009, 32'h08000004, 32'hac010000, 32'hac010008,
    32'h20210006, 32'hac010004, 32'h08000006, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  // addi r0,77; addi r1,5; add r0,r1,r1; sw r0,0; addi r2,r0,1; sw r2,4
  '{32'h2000004d, 32'h20010005, 32'h00210020, 32'hac000000,
    32'h20020001, 32'hac020004, 32'h08000006, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
};

mipsIsaPkg::wordT initData [numTests][2] = '{
  '{32'h0, 32'h0}, '{32'h64, 32'h1234}, '{32'h0, 32'h0}, '{32'h0, 32'h0}, '{32'hffffffff, 32'h0}
};

// address, data
mipsIsaPkg::wordT expStores [numTests][maxStores][2] = '{
  '{'{32'h00, 32'h11}, '{32'h04, 32'h0c}, '{32'h08, 32'h00},
    '{32'h0c, 32'h1d}, '{32'h10, 32'h00}, '{32'h14, 32'h01}},
  '{'{32'h20, 32'h6b}, '{32'h24, 32'h2468}, '{32'h28, 32'h1234},
    '{32'h2c, 32'h6c}, '{32'h0, 32'h0}, '{32'h0, 32'h0}},
  '{'{32'h40, 32'h03}, '{32'h44, 32'h02}, '{32'h48, 32'h01},
    '{32'h80, 32'h00}, '{32'h84, 32'h0c}, '{32'h8c, 32'h0c}},
  '{'{32'h04, 32'h0f}, '{32'h0, 32'h0}, '{32'h0, 32'h0},
    '{32'h0, 32'h0}, '{32'h0, 32'h0}, '{32'h0, 32'h0}},
  '{'{32'h00, 32'h00}, '{32'h04, 32'h01}, '{32'h0, 32'h0},
    '{32'h0, 32'h0}, '{32'h0, 32'h0}, '{32'h0, 32'h0}}
};

`endif

// ==== test/mipsPipeTb.sv ====
// testbench for the five-stage MIPS pipeline
// models both memories, runs each program from reset and checks
// every store against the table, plus the reset state of the ports
module mipsPipeTb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "tbPrograms.svh"

  logic clock;
  logic arstN;
  logic dmemRead;
  logic dmemWrite;
  mipsIsaPkg::wordT imemAddr;
  mipsIsaPkg::wordT imemData;
  mipsIsaPkg::wordT dmemAddr;
  mipsIsaPkg::wordT dmemWData;
  mipsIsaPkg::wordT dmemRData;
  mipsIsaPkg::wordT imem [imemWords];
  mipsIsaPkg::wordT dmem [dmemWords];
  int cycleCount;
  int cycleLimit;

  mipsPipe dut0 (
    .clock(clock),
    .arstN(arstN),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .dmemAddr(dmemAddr),
    .dmemWData(dmemWData),
    .dmemRead(dmemRead),
    .dmemWrite(dmemWrite),
    .dmemRData(dmemRData)
  );

  // both answer in the same cycle, word index = byte address / 4
  assign imemData = imem[imemAddr[6:2]];
  assign dmemRData = dmem[dmemAddr[7:2]];

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic compareValue(input string name, input string what,
                              input mipsIsaPkg::wordT expected,
                              input mipsIsaPkg::wordT actual);
    if (actual !== expected) begin
      failRun($sformatf("Error %s %s expected %h actual %h", name, what, expected, actual));
    end
  endtask

  task automatic loadMemories(input int t);
    for (int i = 0; i < imemWords; i++) begin
      if (i < maxInst) begin
        imem[i] = progTable[t][i];
      end else begin
        imem[i] = {6'h3f, 26'(i)};  // unused opcode, decodes as a bubble
      end
    end
    for (int i = 0; i < dmemWords; i++) begin
      dmem[i] = 32'hc0de0000 + (i << 2);  // tagged with its byte address
    end
    dmem[0] = initData[t][0];
    dmem[1] = initData[t][1];
  endtask

  // per test: 4 cycles per listed instruction plus 40
  function automatic int runCycleLimit();
    int total;
    total = 0;
    for (int t = 0; t < numTests; t++) begin
      total += 4 * instCount[t] + 40;
    end
    return total;
  endfunction

  initial begin
    cycleCount = 0;
    cycleLimit = runCycleLimit();
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    failRun($sformatf("run timed out after %0d cycles", cycleLimit));
  end

  initial begin
    int seen;
    int quiet;
    arstN = 1'b0;
    loadMemories(0);
    for (int t = 0; t < numTests; t++) begin
      @(negedge clock);
      arstN = 1'b0;
      loadMemories(t);
      repeat (10) begin
        @(negedge clock);
        compareValue(testName[t], "dmemWrite in reset", '0, {31'b0, dmemWrite});
        compareValue(testName[t], "dmemRead in reset", '0, {31'b0, dmemRead});
        compareValue(testName[t], "imemAddr in reset", '0, imemAddr);
      end
      arstN = 1'b1;
      #1;  // first cycle out of reset
      compareValue(testName[t], "dmemWrite after reset", '0, {31'b0, dmemWrite});
      compareValue(testName[t], "dmemRead after reset", '0, {31'b0, dmemRead});
      compareValue(testName[t], "imemAddr after reset", '0, imemAddr);
      seen = 0;
      quiet = 0;
      while (seen < storeCount[t] || quiet < 20) begin
        @(negedge clock);  // mid cycle, store strobe settled
        if (dmemWrite && seen >= storeCount[t]) begin
          failRun($sformatf("%s made an extra store to address %h", testName[t], dmemAddr));
        end else if (dmemWrite) begin
          compareValue(testName[t], "store address", expStores[t][seen][0], dmemAddr);
          compareValue(testName[t], "store data", expStores[t][seen][1], dmemWData);
          dmem[dmemAddr[7:2]] = dmemWData;
          seen++;
        end else if (seen >= storeCount[t]) begin
          quiet++;
        end
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== verilog/mipsPipe.sv ====
// five-stage MIPS integer pipeline
// fetch, decode, execute and memory/writeback stages with external
// instruction and data memories answering in the same cycle
module mipsPipe (
  input  logic              clock,
  input  logic              arstN,
  output mipsIsaPkg::wordT  imemAddr,
  input  mipsIsaPkg::wordT  imemData,
  output mipsIsaPkg::wordT  dmemAddr,
  output mipsIsaPkg::wordT  dmemWData,
  output logic              dmemRead,
  output logic              dmemWrite,
  input  mipsIsaPkg::wordT  dmemRData
);

  pipePkg::ifIdT ifId;
  pipePkg::idExT idEx;
  pipePkg::exMemT exMem;
  pipePkg::wbT wb;
  logic stall;
  logic redirect;
  mipsIsaPkg::wordT redirectPc;

  fetchStage uFetch (
    .clock(clock),
    .arstN(arstN),
    .stall(stall),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .imemData(imemData),
    .imemAddr(imemAddr),
    .ifId(ifId)
  );

  decodeStage uDecode (
    .clock(clock),
    .arstN(arstN),
    .ifId(ifId),
    .exMem(exMem),       // branch hazards and compare bypass
    .wb(wb),             // register file write
    .stall(stall),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .idEx(idEx)
  );

  executeStage uExecute (
    .clock(clock),
    .arstN(arstN),
    .idEx(idEx),
    .wb(wb),
    .exMem(exMem)
  );

  memWriteback uMemWb (
    .clock(clock),
    .arstN(arstN),
    .exMem(exMem),
    .dmemRData(dmemRData),
    .dmemAddr(dmemAddr),
    .dmemWData(dmemWData),
    .dmemRead(dmemRead),
    .dmemWrite(dmemWrite),
    .wb(wb)
  );

endmodule

// ==== verilog/memWriteback.sv ====
// memory access and writeback
// drives the data memory port from EX/MEM, registers MEM/WB and
// presents the writeback bus to the register file and forwarding
module memWriteback (
  input  logic              clock,
  input  logic              arstN,
  input  pipePkg::exMemT    exMem,
  input  mipsIsaPkg::wordT  dmemRData,
  output mipsIsaPkg::wordT  dmemAddr,
  output mipsIsaPkg::wordT  dmemWData,
  output logic              dmemRead,
  output logic              dmemWrite,
  output pipePkg::wbT       wb
);

  logic wbRegWrite;
  logic wbMemToReg;
  mipsIsaPkg::regIdxT wbDest;
  mipsIsaPkg::wordT loadData;
  mipsIsaPkg::wordT aluResult;

  assign dmemAddr = exMem.aluResult;  // byte address
  assign dmemWData = exMem.storeData;
  assign dmemRead = exMem.ctl.memRead;
  assign dmemWrite = exMem.ctl.memWrite;  // store strobe, one cycle

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      wbRegWrite <= 1'b0;
      wbMemToReg <= 1'b0;
      wbDest <= '0;
    end else begin
      wbRegWrite <= exMem.ctl.regWrite;
      wbMemToReg <= exMem.ctl.memToReg;
      wbDest <= exMem.dest;
    end
  end

  always_ff @(posedge clock) begin
    loadData <= dmemRData;
    aluResult <= exMem.aluResult;
  end

  always_comb begin
    wb.regWrite = wbRegWrite;
    wb.dest = wbDest;
    wb.data = wbMemToReg ? loadData : aluResult;
  end

endmodule

// ==== verilog/executeStage.sv ====
// execute
// forwarding from the memory and writeback stages, operand muxes,
// the ALU, destination choice and the EX/MEM register
module executeStage (
  input  logic            clock,
  input  logic            arstN,
  input  pipePkg::idExT   idEx,
  input  pipePkg::wbT     wb,
  output pipePkg::exMemT  exMem
);

  pipePkg::fwdSelT fwdA;
  pipePkg::fwdSelT fwdB;
  mipsIsaPkg::wordT opA;
  mipsIsaPkg::wordT regB;   // forwarded rt, also the store data
  mipsIsaPkg::wordT opB;
  mipsIsaPkg::wordT aluResult;
  mipsIsaPkg::regIdxT dest;

  // memory stage first, it holds the younger result
  function automatic pipePkg::fwdSelT pickSource(mipsIsaPkg::regIdxT src,
                                                 pipePkg::exMemT memStage,
                                                 pipePkg::wbT wbStage);
    if (src == '0) begin
      return pipePkg::fwdReg;  // r0 never forwards
    end
    if (memStage.ctl.regWrite && memStage.dest == src) begin
      return pipePkg::fwdMem;
    end
    if (wbStage.regWrite && wbStage.dest == src) begin
      return pipePkg::fwdWb;
    end
    return pipePkg::fwdReg;
  endfunction

  function automatic mipsIsaPkg::wordT muxOperand(pipePkg::fwdSelT sel,
                                                  mipsIsaPkg::wordT regVal,
                                                  mipsIsaPkg::wordT memVal,
                                                  mipsIsaPkg::wordT wbVal);
    case (sel)
      pipePkg::fwdMem: return memVal;
      pipePkg::fwdWb: return wbVal;
      default: return regVal;
    endcase
  endfunction

  assign fwdA = pickSource(idEx.rs, exMem, wb);
  assign fwdB = pickSource(idEx.rt, exMem, wb);
  assign opA = muxOperand(fwdA, idEx.dataA, exMem.aluResult, wb.data);
  assign regB = muxOperand(fwdB, idEx.dataB, exMem.aluResult, wb.data);
  assign opB = idEx.ctl.aluSrcImm ? idEx.imm : regB;

  always_comb begin
    case (idEx.ctl.aluOp)
      pipePkg::aluSub: aluResult = opA - opB;
      pipePkg::aluAnd: aluResult = opA & opB;
      pipePkg::aluOr: aluResult = opA | opB;
      pipePkg::aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      default: aluResult = opA + opB;  // add, also address calc
    endcase
  end

  assign dest = idEx.ctl.regDstRd ? idEx.rd : idEx.rt;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem <= '{ctl: idEx.ctl, aluResult: aluResult, storeData: regB, dest: dest};
    end
  end

  // decoder never builds a read-modify-write access
  memRwExclusive: assert property (
    @(posedge clock) disable iff (!arstN) !(idEx.ctl.memRead && idEx.ctl.memWrite)
  ) else $error("load and store flags set together");

endmodule

// ==== verilog/decodeStage.sv ====
// instruction decode
// field split, sign extension, branch compare in decode, load-use and
// branch hazard stalls, and the ID/EX register
module decodeStage (
  input  logic              clock,
  input  logic              arstN,
  input  pipePkg::ifIdT     ifId,
  input  pipePkg::exMemT    exMem,
  input  pipePkg::wbT       wb,
  output logic              stall,
  output logic              redirect,
  output mipsIsaPkg::wordT  redirectPc,
  output pipePkg::idExT     idEx
);

  mipsIsaPkg::opcodeT opcode;
  mipsIsaPkg::functT funct;
  mipsIsaPkg::regIdxT rs;
  mipsIsaPkg::regIdxT rt;
  mipsIsaPkg::regIdxT rd;
  mipsIsaPkg::regIdxT exDest;
  mipsIsaPkg::wordT regA;
  mipsIsaPkg::wordT regB;
  mipsIsaPkg::wordT cmpA;
  mipsIsaPkg::wordT cmpB;
  mipsIsaPkg::wordT imm;
  mipsIsaPkg::wordT branchTarget;
  mipsIsaPkg::wordT jumpTarget;
  pipePkg::ctlT ctl;
  logic isBeq;
  logic isBne;
  logic isJump;
  logic memFwd;
  logic taken;
  logic loadUse;
  logic branchHazard;

  assign opcode = ifId.inst[31:26];
  assign rs = ifId.inst[25:21];
  assign rt = ifId.inst[20:16];
  assign rd = ifId.inst[15:11];
  assign funct = ifId.inst[5:0];
  assign imm = {{16{ifId.inst[15]}}, ifId.inst[15:0]};

  controlDecoder uCtl (.opcode(opcode), .funct(funct), .ctl(ctl),
                       .isBeq(isBeq), .isBne(isBne), .isJump(isJump));

  regFile uRegs (.clock(clock), .arstN(arstN), .wb(wb), .rs(rs), .rt(rt),
                 .dataA(regA), .dataB(regB));

  // alu result sitting in memory feeds the compare directly
  assign memFwd = exMem.ctl.regWrite && !exMem.ctl.memToReg && exMem.dest != '0;
  assign cmpA = (memFwd && exMem.dest == rs) ? exMem.aluResult : regA;
  assign cmpB = (memFwd && exMem.dest == rt) ? exMem.aluResult : regB;

  assign branchTarget = ifId.pcPlus4 + {imm[29:0], 2'b00};
  assign jumpTarget = {ifId.pcPlus4[31:28], ifId.inst[25:0], 2'b00};  // own PC+4 region

  assign exDest = idEx.ctl.regDstRd ? idEx.rd : idEx.rt;

  // load in execute feeding this instruction, one bubble
  assign loadUse = idEx.ctl.memRead && idEx.rt != '0 && (idEx.rt == rs || idEx.rt == rt);
  // branch sources not yet readable: any result in EX, load data in MEM
  assign branchHazard = (isBeq || isBne) &&
    ((idEx.ctl.regWrite && exDest != '0 && (exDest == rs || exDest == rt)) ||
     (exMem.ctl.memRead && exMem.dest != '0 && (exMem.dest == rs || exMem.dest == rt)));
  assign stall = loadUse || branchHazard;

  assign taken = (isBeq && cmpA == cmpB) || (isBne && cmpA != cmpB);
  assign redirect = !stall && (taken || isJump);  // compare only valid once clear
  assign redirectPc = isJump ? jumpTarget : branchTarget;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else if (stall) begin
      idEx <= '0;  // bubble while decode waits
    end else begin
      idEx <= '{ctl: ctl, dataA: regA, dataB: regB, imm: imm, rs: rs, rt: rt, rd: rd};
    end
  end

  noStallRedirect: assert property (
    @(posedge clock) disable iff (!arstN) !(stall && redirect)
  ) else $error("redirect raised during a stall");

  // flushed slot in IF/ID must not redirect again
  redirectOnce: assert property (
    @(posedge clock) disable iff (!arstN) redirect |=> !redirect
  ) else $error("back to back redirects");

endmodule

// ==== verilog/fetchStage.sv ====
// instruction fetch
// program counter, next PC choice and the IF/ID register,
// held on a decode stall and flushed on a redirect
module fetchStage (
  input  logic              clock,
  input  logic              arstN,
  input  logic              stall,       // hold PC and IF/ID
  input  logic              redirect,    // taken branch or jump in decode
  input  mipsIsaPkg::wordT  redirectPc,
  input  mipsIsaPkg::wordT  imemData,
  output mipsIsaPkg::wordT  imemAddr,
  output pipePkg::ifIdT     ifId
);

  mipsIsaPkg::wordT pc;
  mipsIsaPkg::wordT pcPlus4;
  mipsIsaPkg::wordT nextPc;

  assign pcPlus4 = pc + 32'd4;
  assign nextPc = redirect ? redirectPc : pcPlus4;  // no delay slot
  assign imemAddr = pc;  // memory answers in the same cycle

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= nextPc;
    end
  end

  // IF/ID, zero word is a bubble in decode
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      ifId <= '0;
    end else if (redirect) begin
      ifId <= '0;  // drop the wrong-path fetch
    end else if (!stall) begin
      ifId.inst <= imemData;
      ifId.pcPlus4 <= pcPlus4;
    end
  end

  // branch and jump targets from decode must stay word aligned
  pcAligned: assert property (
    @(posedge clock) disable iff (!arstN) pc[1:0] == 2'b00
  ) else $error("fetch PC not word aligned");

endmodule

// ==== verilog/regFile.sv ====
// register file
// 32 words, two read ports, one write port from writeback,
// r0 reads zero and writes pass straight through to the readers
module regFile (
  input  logic                clock,
  input  logic                arstN,
  input  pipePkg::wbT         wb,
  input  mipsIsaPkg::regIdxT  rs,
  input  mipsIsaPkg::regIdxT  rt,
  output mipsIsaPkg::wordT    dataA,
  output mipsIsaPkg::wordT    dataB
);

  mipsIsaPkg::wordT regs [mipsIsaPkg::regCount];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < mipsIsaPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.regWrite && wb.dest != '0) begin
      regs[wb.dest] <= wb.data;  // r0 stays zero
    end
  end

  // write-through, decode sees this cycle's writeback
  assign dataA = (rs == '0) ? '0 :
                 (wb.regWrite && wb.dest == rs) ? wb.data : regs[rs];
  assign dataB = (rt == '0) ? '0 :
                 (wb.regWrite && wb.dest == rt) ? wb.data : regs[rt];

endmodule

// ==== verilog/controlDecoder.sv ====
// main control decode
// opcode and function field to the control bundle and ALU operation,
// plus branch and jump flags used in decode
module controlDecoder (
  input  mipsIsaPkg::opcodeT  opcode,
  input  mipsIsaPkg::functT   funct,
  output pipePkg::ctlT        ctl,
  output logic                isBeq,
  output logic                isBne,
  output logic                isJump
);

  always_comb begin
    ctl = '0;  // unknown encodings fall out as a bubble
    isBeq = 1'b0;
    isBne = 1'b0;
    isJump = 1'b0;
    case (opcode)
      mipsIsaPkg::opRType: begin
        ctl.regWrite = 1'b1;
        ctl.regDstRd = 1'b1;
        case (funct)
          mipsIsaPkg::fnAdd: ctl.aluOp = pipePkg::aluAdd;
          mipsIsaPkg::fnSub: ctl.aluOp = pipePkg::aluSub;
          mipsIsaPkg::fnAnd: ctl.aluOp = pipePkg::aluAnd;
          mipsIsaPkg::fnOr: ctl.aluOp = pipePkg::aluOr;
          mipsIsaPkg::fnSlt: ctl.aluOp = pipePkg::aluSlt;
          default: ctl = '0;  // includes the all-zero flush word
        endcase
      end
      mipsIsaPkg::opLw: begin
        ctl.regWrite = 1'b1;
        ctl.memToReg = 1'b1;
        ctl.memRead = 1'b1;
        ctl.aluSrcImm = 1'b1;  // base + offset
        ctl.aluOp = pipePkg::aluAdd;
      end
      mipsIsaPkg::opSw: begin
        ctl.memWrite = 1'b1;
        ctl.aluSrcImm = 1'b1;
        ctl.aluOp = pipePkg::aluAdd;
      end
      mipsIsaPkg::opAddi: begin
        ctl.regWrite = 1'b1;
        ctl.aluSrcImm = 1'b1;
        ctl.aluOp = pipePkg::aluAdd;
      end
      mipsIsaPkg::opBeq: isBeq = 1'b1;  // resolved in decode, bubble downstream
      mipsIsaPkg::opBne: isBne = 1'b1;
      mipsIsaPkg::opJ: isJump = 1'b1;
      default: ctl = '0;
    endcase
  end

endmodule

// ==== verilog/pipePkg.sv ====
// pipeline definitions
// control bundle, stage register layouts, writeback bus
// and the ALU and forwarding selector codes
package pipePkg;

  // ALU operation
  typedef logic [2:0] aluOpT;
  localparam aluOpT aluAdd = 3'd0;
  localparam aluOpT aluSub = 3'd1;
  localparam aluOpT aluAnd = 3'd2;
  localparam aluOpT aluOr = 3'd3;
  localparam aluOpT aluSlt = 3'd4;  // signed compare, result 0 or 1

  // operand source in execute
  typedef logic [1:0] fwdSelT;
  localparam fwdSelT fwdReg = 2'd0;  // value read in decode
  localparam fwdSelT fwdMem = 2'd1;  // EX/MEM alu result
  localparam fwdSelT fwdWb = 2'd2;   // writeback bus

  // all zero means bubble
  typedef struct packed {
    logic regWrite;
    logic memToReg;   // writeback takes load data
    logic memRead;
    logic memWrite;
    logic aluSrcImm;  // operand B from the immediate
    logic regDstRd;   // dest is rd, else rt
    aluOpT aluOp;
  } ctlT;

  typedef struct packed {
    mipsIsaPkg::wordT inst;
    mipsIsaPkg::wordT pcPlus4;
  } ifIdT;

  typedef struct packed {
    ctlT ctl;
    mipsIsaPkg::wordT dataA;
    mipsIsaPkg::wordT dataB;
    mipsIsaPkg::wordT imm;  // already sign extended
    mipsIsaPkg::regIdxT rs;
    mipsIsaPkg::regIdxT rt;
    mipsIsaPkg::regIdxT rd;
  } idExT;

  typedef struct packed {
    ctlT ctl;
    mipsIsaPkg::wordT aluResult;  // also the data memory address
    mipsIsaPkg::wordT storeData;
    mipsIsaPkg::regIdxT dest;
  } exMemT;

  // writeback bus, shared by the register file and forwarding
  typedef struct packed {
    logic regWrite;
    mipsIsaPkg::regIdxT dest;
    mipsIsaPkg::wordT data;
  } wbT;

endpackage

// ==== verilog/mipsIsaPkg.sv ====
// MIPS ISA definitions
// word and field widths, major opcodes and R-type function codes
// for the integer subset run by the five-stage pipeline
package mipsIsaPkg;

  localparam int wordWidth = 32;   // data and address width
  localparam int regIdxWidth = 5;  // register number width
  localparam int regCount = 32;    // architectural registers

  typedef logic [wordWidth-1:0] wordT;      // data or byte address
  typedef logic [regIdxWidth-1:0] regIdxT;  // rs, rt, rd
  typedef logic [5:0] opcodeT;              // inst[31:26]
  typedef logic [5:0] functT;               // inst[5:0], R-type only

  // major opcodes
  localparam opcodeT opRType = 6'h00;
  localparam opcodeT opJ = 6'h02;
  localparam opcodeT opBeq = 6'h04;
  localparam opcodeT opBne = 6'h05;
  localparam opcodeT opAddi = 6'h08;
  localparam opcodeT opLw = 6'h23;
  localparam opcodeT opSw = 6'h2b;

  // R-type function codes, anything else decodes to a bubble
  localparam functT fnAdd = 6'h20;
  localparam functT fnSub = 6'h22;
  localparam functT fnAnd = 6'h24;
  localparam functT fnOr = 6'h25;
  localparam functT fnSlt = 6'h2a;

endpackage
